// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_des_core
FILELIST  = build.f
OBJDIR    = obj_dir
LOG       = sim.log
PASS_MSG  = ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: bench/des_core_asserts.sv
`timescale 1ns/1ps

module des_core_asserts
	import des_types_pkg::*;
(
	input logic   clk,
	input logic   rst,
	input logic   i_valid,
	input block_t i_block
);

	// result is shown for one cycle only
	a_single_pulse: assert property (@(posedge clk) disable iff (rst) i_valid |=> !i_valid)
		else $error("o_valid stayed high for two cycles");

	a_block_gated: assert property (@(posedge clk) disable iff (rst) !i_valid |-> i_block == '0)
		else $error("o_block nonzero while o_valid is low");

endmodule

// File: bench/des_ref.svh
`ifndef DES_REF_SVH
`define DES_REF_SVH

// textbook DES, all sixteen subkeys first and then the rounds
function automatic block_t des_ref(
	input des_mode_e mode,
	input key_t      key,
	input block_t    blk
);
	logic [55:0] cd;
	logic [27:0] c;
	logic [27:0] d;
	logic [47:0] ks [16];
	logic [47:0] e;
	logic [5:0]  grp;
	logic [31:0] s;
	logic [31:0] f;
	logic [31:0] l;
	logic [31:0] r;
	logic [31:0] t;
	logic [63:0] perm;
	logic [63:0] pre;
	block_t      res;
	int          shifts;

	for (int i = 0; i < 56; i++)
		cd[55 - i] = key[64 - PC1_TABLE[i]];
	c = cd[55:28];
	d = cd[27:0];
	for (int n = 0; n < 16; n++)
	begin
		shifts = (n == 0 || n == 1 || n == 8 || n == 15) ? 1 : 2;
		for (int k = 0; k < shifts; k++)
		begin
			c = {c[26:0], c[27]};
			d = {d[26:0], d[27]};
		end
		cd = {c, d};
		for (int i = 0; i < 48; i++)
			ks[n][47 - i] = cd[56 - PC2_TABLE[i]];
	end

	for (int i = 0; i < 64; i++)
		perm[63 - i] = blk[64 - IP_TABLE[i]];
	l = perm[63:32];
	r = perm[31:0];
	for (int n = 0; n < 16; n++)
	begin
		for (int i = 0; i < 48; i++)
			e[47 - i] = r[32 - E_TABLE[i]];
		e = e ^ ((mode == MODE_DECRYPT) ? ks[15 - n] : ks[n]); // subkeys backwards for decrypt
		for (int b = 0; b < 8; b++)
		begin
			grp = e[47 - 6 * b -: 6];
			s[31 - 4 * b -: 4] = SBOX[b][{grp[5], grp[0], grp[4:1]}];
		end
		for (int i = 0; i < 32; i++)
			f[31 - i] = s[32 - P_TABLE[i]];
		t = r;
		r = l ^ f;
		l = t;
	end

	pre = {r, l}; // undo the last swap
	for (int i = 0; i < 64; i++)
		res[63 - i] = pre[64 - FP_TABLE[i]];
	return res;
endfunction

`endif

// File: bench/tb_des_core.sv
`timescale 1ns/1ps

module tb_des_core
	import des_types_pkg::*;
	import des_tables_pkg::*;
();

	`include "des_ref.svh"

	localparam int     TIMEOUT     = 40;
	localparam int     DRIVE_DLY   = 1;
	localparam key_t   KAT_KEY     = 64'h1334_5779_9BBC_DFF1;
	localparam block_t KAT_PT      = 64'h0123_4567_89AB_CDEF;
	localparam block_t KAT_CT      = 64'h85E8_1354_0F0A_B405;
	localparam key_t   PARITY_BITS = 64'h0101_0101_0101_0101;

	typedef struct packed
	{
		block_t      expected;
		logic [31:0] start_cyc; // cycle of the sampling edge
	} exp_rec_t;

	logic      clk;
	logic      rst;
	logic      i_start;
	des_mode_e i_mode;
	key_t      i_key;
	block_t    i_block;
	logic      o_valid;
	block_t    o_block;

	exp_rec_t exp_q [$];
	int       cyc = 0;
	int       checks = 0;
	int       errors = 0;

	des_core dut0 (
		.clk     (clk),
		.rst     (rst),
		.i_start (i_start),
		.i_mode  (i_mode),
		.i_key   (i_key),
		.i_block (i_block),
		.o_valid (o_valid),
		.o_block (o_block)
	);

	bind des_core des_core_asserts u_asserts (
		.clk     (clk),
		.rst     (rst),
		.i_valid (o_valid),
		.i_block (o_block)
	);

	always #50 clk = ~clk;

	always @(posedge clk) cyc <= cyc + 1;

	// outputs are settled on the falling edge
	always @(negedge clk)
	begin : compare_proc
		exp_rec_t rec;

		if (!rst && o_valid && exp_q.size() == 0)
		begin
			errors++;
			$display("unexpected o_valid pulse at %0t with no request pending", $time);
		end
		else if (!rst && o_valid)
		begin
			rec = exp_q.pop_front();
			checks += 2;
			assert (o_block == rec.expected)
			else
			begin
				errors++;
				$display("CHECK FAILED at %0t: o_block expected %h, got %h",
					$time, rec.expected, o_block);
			end
			assert (cyc == int'(rec.start_cyc) + 16) // 16 edges after the start edge
			else
			begin
				errors++;
				$display("CHECK FAILED at %0t: o_valid edge expected %0d, got %0d",
					$time, int'(rec.start_cyc) + 16, cyc);
			end
		end
		else if (!rst)
		begin
			checks++;
			assert (o_block == '0)
			else
			begin
				errors++;
				$display("CHECK FAILED at %0t: o_block expected %h, got %h", $time, 64'h0, o_block);
			end
		end
	end

	task automatic report_and_finish();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	endtask

	task automatic start_op(input des_mode_e mode, input key_t key, input block_t blk,
		input block_t expected);
		exp_rec_t rec;

		@(posedge clk);
		#DRIVE_DLY;
		i_start = 1'b1;
		i_mode  = mode;
		i_key   = key;
		i_block = blk;
		@(posedge clk);
		#DRIVE_DLY;
		rec.expected  = expected;
		rec.start_cyc = cyc;
		exp_q.push_back(rec);
		i_start = 1'b0;
	endtask

	task automatic wait_result();
		int waited;

		waited = 0;
		while (exp_q.size() != 0 && waited < TIMEOUT)
		begin
			@(posedge clk);
			waited++;
		end
		if (exp_q.size() != 0)
		begin
			errors++;
			$display("timeout: no o_valid pulse within %0d cycles of the start", TIMEOUT);
			report_and_finish();
		end
	endtask

	task automatic run_op(input des_mode_e mode, input key_t key, input block_t blk,
		input block_t expected);
		start_op(mode, key, blk, expected);
		wait_result();
	endtask

	initial
	begin : main_proc
		key_t      key;
		block_t    blk;
		block_t    res;
		des_mode_e mode;

		clk     = 1'b0;
		rst     = 1'b1;
		i_start = 1'b0;
		i_mode  = MODE_ENCRYPT;
		i_key   = '0;
		i_block = '0;
		void'($urandom(60));
		repeat (4) @(posedge clk);
		#DRIVE_DLY;
		rst = 1'b0;
		checks++;
		assert (o_valid == 1'b0)
		else
		begin
			errors++;
			$display("CHECK FAILED at %0t: o_valid expected 0, got %b", $time, o_valid);
		end

		// known answer, then back again
		run_op(MODE_ENCRYPT, KAT_KEY, KAT_PT, KAT_CT);
		run_op(MODE_DECRYPT, KAT_KEY, KAT_CT, KAT_PT);

		for (int n = 0; n < 40; n++)
		begin
			key  = {$urandom(), $urandom()};
			blk  = {$urandom(), $urandom()};
			mode = des_mode_e'($urandom_range(1, 0));
			res  = des_ref(mode, key, blk);
			run_op(mode, key, blk, res);
			if (mode == MODE_ENCRYPT)
				run_op(MODE_DECRYPT, key, res, blk);
		end

		// second start while busy must be dropped
		start_op(MODE_ENCRYPT, KAT_KEY, KAT_PT, KAT_CT);
		repeat (5) @(posedge clk);
		#DRIVE_DLY;
		i_start = 1'b1;
		i_mode  = MODE_DECRYPT;
		i_key   = ~KAT_KEY;
		i_block = ~KAT_PT;
		@(posedge clk);
		#DRIVE_DLY;
		i_start = 1'b0;
		wait_result();
		repeat (20) @(posedge clk);

		run_op(MODE_ENCRYPT, KAT_KEY ^ PARITY_BITS, KAT_PT, KAT_CT);
		key = {$urandom(), $urandom()};
		blk = {$urandom(), $urandom()};
		run_op(MODE_ENCRYPT, key ^ PARITY_BITS, blk, des_ref(MODE_ENCRYPT, key, blk));

		repeat (20) @(posedge clk); // catch stray pulses
		report_and_finish();
	end

endmodule

// File: build.f
+incdir+bench
verilog/des_types_pkg.sv
verilog/des_tables_pkg.sv
verilog/des_ctrl.sv
verilog/des_key_schedule.sv
verilog/des_feistel.sv
verilog/des_block_path.sv
verilog/des_core.sv
bench/des_core_asserts.sv
bench/tb_des_core.sv

// File: verilog/des_block_path.sv
`timescale 1ns/1ps

module des_block_path
	import des_types_pkg::*;
	import des_tables_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  round_ctl_t i_ctl,
	input  block_t     i_block,
	input  half_t      i_f,
	output half_t      o_right,
	input  logic       o_valid_window,
	output block_t     o_block
);

	half_t  l_q;
	half_t  r_q;
	half_t  xor_f;
	block_t ip_block;
	block_t lr_fp;

	always_comb
	begin
		for (int i = 0; i < 64; i++)
			ip_block[63 - i] = i_block[64 - IP_TABLE[i]];
	end

	// L/R already sit in R16 L16 order after the unswapped last round
	always_comb
	begin
		for (int i = 0; i < 64; i++)
			lr_fp[63 - i] = {l_q, r_q}[64 - FP_TABLE[i]];
	end

	assign xor_f   = l_q ^ i_f;
	assign o_right = r_q;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			l_q <= '0;
			r_q <= '0;
		end
		else if (i_ctl.load)
		begin
			l_q <= ip_block[63:32];
			r_q <= ip_block[31:0];
		end
		else if (i_ctl.active)
		begin
			if (i_ctl.last)
			begin
				l_q <= xor_f; // no swap, R kept
			end
			else
			begin
				l_q <= r_q;
				r_q <= xor_f;
			end
		end
	end

	assign o_block = o_valid_window ? lr_fp : '0;

endmodule

// File: verilog/des_core.sv
`timescale 1ns/1ps

module des_core
	import des_types_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      i_start,
	input  des_mode_e i_mode,
	input  key_t      i_key,
	input  block_t    i_block,
	output logic      o_valid,
	output block_t    o_block
);

	round_ctl_t ctl;
	subkey_t    subkey;
	half_t      right;
	half_t      f_out;
	logic       valid;

	des_ctrl u_ctrl (
		.clk     (clk),
		.rst     (rst),
		.i_start (i_start),
		.i_mode  (i_mode),
		.o_ctl   (ctl),
		.o_valid (valid)
	);

	des_key_schedule u_key_schedule (
		.clk      (clk),
		.rst      (rst),
		.i_ctl    (ctl),
		.i_key    (i_key),
		.o_subkey (subkey)
	);

	des_feistel u_feistel (
		.i_right  (right),
		.i_subkey (subkey),
		.o_f      (f_out)
	);

	// the same valid gates the output block
	des_block_path u_block_path (
		.clk            (clk),
		.rst            (rst),
		.i_ctl          (ctl),
		.i_block        (i_block),
		.i_f            (f_out),
		.o_right        (right),
		.o_valid_window (valid),
		.o_block        (o_block)
	);

	assign o_valid = valid;

endmodule

// File: verilog/des_ctrl.sv
`timescale 1ns/1ps

module des_ctrl
	import des_types_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       i_start,
	input  des_mode_e  i_mode,
	output round_ctl_t o_ctl,
	output logic       o_valid
);

	des_state_e state;
	des_mode_e  mode_q;
	round_idx_t cnt;
	logic       at_end;

	// decrypt walks the rounds backwards
	assign at_end = (mode_q == MODE_DECRYPT) ? (cnt == '0) :
		(cnt == round_idx_t'(NUM_ROUNDS - 1));

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state  <= ST_IDLE;
			mode_q <= MODE_ENCRYPT;
			cnt    <= '0;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					if (i_start)
					begin
						state  <= ST_ROUND;
						mode_q <= i_mode;
						cnt    <= (i_mode == MODE_DECRYPT) ? round_idx_t'(NUM_ROUNDS - 1) : '0;
					end
				end
				ST_ROUND:
				begin
					if (at_end)
						state <= ST_OUTPUT;
					else if (mode_q == MODE_DECRYPT)
						cnt <= cnt - 4'd1;
					else
						cnt <= cnt + 4'd1;
				end
				ST_OUTPUT: state <= ST_IDLE; // result shown for one cycle only
				default:   state <= ST_IDLE;
			endcase
		end
	end

	always_comb
	begin
		o_ctl.load    = (state == ST_IDLE) && i_start; // busy starts fall through here
		o_ctl.active  = (state == ST_ROUND);
		o_ctl.decrypt = (mode_q == MODE_DECRYPT);
		o_ctl.idx     = cnt;
		o_ctl.last    = (state == ST_ROUND) && at_end;
	end

	assign o_valid = (state == ST_OUTPUT);

endmodule

// File: verilog/des_feistel.sv
`timescale 1ns/1ps

module des_feistel
	import des_types_pkg::*;
	import des_tables_pkg::*;
(
	input  half_t   i_right,
	input  subkey_t i_subkey,
	output half_t   o_f
);

	subkey_t expanded;
	subkey_t mixed;
	half_t   sbox_out;

	always_comb
	begin
		for (int i = 0; i < 48; i++)
			expanded[47 - i] = i_right[32 - E_TABLE[i]];
	end

	assign mixed = expanded ^ i_subkey;

	// box 0 takes the top six bits
	for (genvar b = 0; b < 8; b++)
	begin : g_sbox
		logic [5:0] grp;

		assign grp = mixed[47 - 6 * b -: 6];
		assign sbox_out[31 - 4 * b -: 4] = SBOX[b][{grp[5], grp[0], grp[4:1]}];
	end

	always_comb
	begin
		for (int i = 0; i < 32; i++)
			o_f[31 - i] = sbox_out[32 - P_TABLE[i]];
	end

endmodule

// File: verilog/des_key_schedule.sv
`timescale 1ns/1ps

module des_key_schedule
	import des_types_pkg::*;
	import des_tables_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  round_ctl_t i_ctl,
	input  key_t       i_key,
	output subkey_t    o_subkey
);

	cd_t         cd_q;
	cd_t         pc1_key;
	cd_t         cd_rot_l;
	cd_t         cd_rot_r;
	cd_t         sub_src;
	logic [27:0] c_half;
	logic [27:0] d_half;
	logic        one_place;

	assign c_half    = cd_q[55:28];
	assign d_half    = cd_q[27:0];
	assign one_place = SHIFT_ONE_MASK[i_ctl.idx];

	always_comb
	begin
		for (int i = 0; i < 56; i++)
			pc1_key[55 - i] = i_key[64 - PC1_TABLE[i]];
	end

	// both halves rotate by the same amount
	assign cd_rot_l = one_place ?
		{c_half[26:0], c_half[27], d_half[26:0], d_half[27]} :
		{c_half[25:0], c_half[27:26], d_half[25:0], d_half[27:26]};
	assign cd_rot_r = one_place ?
		{c_half[0], c_half[27:1], d_half[0], d_half[27:1]} :
		{c_half[1:0], c_half[27:2], d_half[1:0], d_half[27:2]};

	// encrypt rotates before selection, decrypt after
	assign sub_src = i_ctl.decrypt ? cd_q : cd_rot_l;

	always_comb
	begin
		for (int i = 0; i < 48; i++)
			o_subkey[47 - i] = sub_src[56 - PC2_TABLE[i]];
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			cd_q <= '0;
		else if (i_ctl.load)
			cd_q <= pc1_key;
		else if (i_ctl.active)
			cd_q <= i_ctl.decrypt ? cd_rot_r : cd_rot_l;
	end

endmodule

// File: verilog/des_tables_pkg.sv
package des_tables_pkg;

	// entries are 1-based source bit positions counted from the MSB

	localparam int IP_TABLE [64] = '{
		58, 50, 42, 34, 26, 18, 10,  2,
		60, 52, 44, 36, 28, 20, 12,  4,
		62, 54, 46, 38, 30, 22, 14,  6,
		64, 56, 48, 40, 32, 24, 16,  8,
		57, 49, 41, 33, 25, 17,  9,  1,
		59, 51, 43, 35, 27, 19, 11,  3,
		61, 53, 45, 37, 29, 21, 13,  5,
		63, 55, 47, 39, 31, 23, 15,  7
	};

	localparam int FP_TABLE [64] = '{
		40,  8, 48, 16, 56, 24, 64, 32,
		39,  7, 47, 15, 55, 23, 63, 31,
		38,  6, 46, 14, 54, 22, 62, 30,
		37,  5, 45, 13, 53, 21, 61, 29,
		36,  4, 44, 12, 52, 20, 60, 28,
		35,  3, 43, 11, 51, 19, 59, 27,
		34,  2, 42, 10, 50, 18, 58, 26,
		33,  1, 41,  9, 49, 17, 57, 25
	};

	// parity bits 8, 16, .. 64 never appear
	localparam int PC1_TABLE [56] = '{
		57, 49, 41, 33, 25, 17,  9,
		 1, 58, 50, 42, 34, 26, 18,
		10,  2, 59, 51, 43, 35, 27,
		19, 11,  3, 60, 52, 44, 36,
		63, 55, 47, 39, 31, 23, 15,
		 7, 62, 54, 46, 38, 30, 22,
		14,  6, 61, 53, 45, 37, 29,
		21, 13,  5, 28, 20, 12,  4
	};

	localparam int PC2_TABLE [48] = '{
		14, 17, 11, 24,  1,  5,
		 3, 28, 15,  6, 21, 10,
		23, 19, 12,  4, 26,  8,
		16,  7, 27, 20, 13,  2,
		41, 52, 31, 37, 47, 55,
		30, 40, 51, 45, 33, 48,
		44, 49, 39, 56, 34, 53,
		46, 42, 50, 36, 29, 32
	};

	localparam int E_TABLE [48] = '{
		32,  1,  2,  3,  4,  5,
		 4,  5,  6,  7,  8,  9,
		 8,  9, 10, 11, 12, 13,
		12, 13, 14, 15, 16, 17,
		16, 17, 18, 19, 20, 21,
		20, 21, 22, 23, 24, 25,
		24, 25, 26, 27, 28, 29,
		28, 29, 30, 31, 32,  1
	};

	localparam int P_TABLE [32] = '{
		16,  7, 20, 21, 29, 12, 28, 17,
		 1, 15, 23, 26,  5, 18, 31, 10,
		 2,  8, 24, 14, 32, 27,  3,  9,
		19, 13, 30,  6, 22, 11,  4, 25
	};

	// index is {row, col}, row from the outer bits of the group
	localparam logic [3:0] SBOX [8][64] = '{
		'{
			14,  4, 13,  1,  2, 15, 11,  8,  3, 10,  6, 12,  5,  9,  0,  7,
			 0, 15,  7,  4, 14,  2, 13,  1, 10,  6, 12, 11,  9,  5,  3,  8,
			 4,  1, 14,  8, 13,  6,  2, 11, 15, 12,  9,  7,  3, 10,  5,  0,
			15, 12,  8,  2,  4,  9,  1,  7,  5, 11,  3, 14, 10,  0,  6, 13
		},
		'{
			15,  1,  8, 14,  6, 11,  3,  4,  9,  7,  2, 13, 12,  0,  5, 10,
			 3, 13,  4,  7, 15,  2,  8, 14, 12,  0,  1, 10,  6,  9, 11,  5,
			 0, 14,  7, 11, 10,  4, 13,  1,  5,  8, 12,  6,  9,  3,  2, 15,
			13,  8, 10,  1,  3, 15,  4,  2, 11,  6,  7, 12,  0,  5, 14,  9
		},
		'{
			10,  0,  9, 14,  6,  3, 15,  5,  1, 13, 12,  7, 11,  4,  2,  8,
			13,  7,  0,  9,  3,  4,  6, 10,  2,  8,  5, 14, 12, 11, 15,  1,
			13,  6,  4,  9,  8, 15,  3,  0, 11,  1,  2, 12,  5, 10, 14,  7,
			 1, 10, 13,  0,  6,  9,  8,  7,  4, 15, 14,  3, 11,  5,  2, 12
		},
		'{
			 7, 13, 14,  3,  0,  6,  9, 10,  1,  2,  8,  5, 11, 12,  4, 15,
			13,  8, 11,  5,  6, 15,  0,  3,  4,  7,  2, 12,  1, 10, 14,  9,
			10,  6,  9,  0, 12, 11,  7, 13, 15,  1,  3, 14,  5,  2,  8,  4,
			 3, 15,  0,  6, 10,  1, 13,  8,  9,  4,  5, 11, 12,  7,  2, 14
		},
		'{
			 2, 12,  4,  1,  7, 10, 11,  6,  8,  5,  3, 15, 13,  0, 14,  9,
			14, 11,  2, 12,  4,  7, 13,  1,  5,  0, 15, 10,  3,  9,  8,  6,
			 4,  2,  1, 11, 10, 13,  7,  8, 15,  9, 12,  5,  6,  3,  0, 14,
			11,  8, 12,  7,  1, 14,  2, 13,  6, 15,  0,  9, 10,  4,  5,  3
		},
		'{
			12,  1, 10, 15,  9,  2,  6,  8,  0, 13,  3,  4, 14,  7,  5, 11,
			10, 15,  4,  2,  7, 12,  9,  5,  6,  1, 13, 14,  0, 11,  3,  8,
			 9, 14, 15,  5,  2,  8, 12,  3,  7,  0,  4, 10,  1, 13, 11,  6,
			 4,  3,  2, 12,  9,  5, 15, 10, 11, 14,  1,  7,  6,  0,  8, 13
		},
		'{
			 4, 11,  2, 14, 15,  0,  8, 13,  3, 12,  9,  7,  5, 10,  6,  1,
			13,  0, 11,  7,  4,  9,  1, 10, 14,  3,  5, 12,  2, 15,  8,  6,
			 1,  4, 11, 13, 12,  3,  7, 14, 10, 15,  6,  8,  0,  5,  9,  2,
			 6, 11, 13,  8,  1,  4, 10,  7,  9,  5,  0, 15, 14,  2,  3, 12
		},
		'{
			13,  2,  8,  4,  6, 15, 11,  1, 10,  9,  3, 14,  5,  0, 12,  7,
			 1, 15, 13,  8, 10,  3,  7,  4, 12,  5,  6, 11,  0, 14,  9,  2,
			 7, 11,  4,  1,  9, 12, 14,  2,  0,  6, 10, 13, 15,  3,  5,  8,
			 2,  1, 14,  7,  4, 10,  8, 13, 15, 12,  9,  0,  3,  5,  6, 11
		}
	};

	// rounds 0, 1, 8 and 15 rotate by one place, the rest by two
	localparam logic [15:0] SHIFT_ONE_MASK = 16'b1000_0001_0000_0011;

endpackage

// File: verilog/des_types_pkg.sv
package des_types_pkg;

	localparam int NUM_ROUNDS = 16;

	typedef logic [63:0] block_t;
	typedef logic [63:0] key_t;   // includes the 8 parity bits
	typedef logic [55:0] cd_t;    // C in [55:28], D in [27:0]
	typedef logic [31:0] half_t;
	typedef logic [47:0] subkey_t;
	typedef logic [3:0]  round_idx_t;

	typedef enum logic
	{
		MODE_ENCRYPT = 1'b0,
		MODE_DECRYPT = 1'b1
	} des_mode_e;

	typedef enum logic [1:0]
	{
		ST_IDLE   = 2'd0,
		ST_ROUND  = 2'd1,
		ST_OUTPUT = 2'd2
	} des_state_e;

	// broadcast from the sequencer to key schedule and block path
	typedef struct packed
	{
		logic       load;
		logic       active;
		logic       decrypt;
		round_idx_t idx;     // encrypt numbering in both modes
		logic       last;
	} round_ctl_t;

endpackage
